//--- hdl/afu_macros.svh
`ifndef AFU_MACROS_SVH
`define AFU_MACROS_SVH

// host address and buffer beat widths
`define AFU_ADDR_W 64
`define AFU_DATA_W 64

// command tag width, beats per cache line
`define AFU_TAG_W 8
`define AFU_BEATS 4

// mmio word address width
`define AFU_MMIO_AW 24

// fixed tags for the descriptor read and the result write
// line reads use the line index, so these sit at the top of the range
`define AFU_WED_TAG 8'hfe
`define AFU_WR_TAG 8'hff

// value returned at the descriptor offset
`define AFU_DESC_WORD 64'h0000_0001_0000_8010

`endif

//--- hdl/capi_pkg.sv
package capi_pkg;

  // job control commands from the host
  typedef enum logic [1:0] {
    JOB_NONE  = 2'd0,
    JOB_START = 2'd1,
    JOB_RESET = 2'd2
  } job_cmd_e;

  // memory commands issued by the afu
  typedef enum logic [1:0] {
    MEM_IDLE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_cmd_e;

  // response codes returned by the host
  typedef enum logic [1:0] {
    RESP_DONE   = 2'd0,
    RESP_FAILED = 2'd1
  } resp_code_e;

endpackage

//--- hdl/afu_pkg.sv
`include "afu_macros.svh"

package afu_pkg;

  // sequencer states, request/wait pairs in command order
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_WED_REQ   = 3'd1,
    ST_WED_WAIT  = 3'd2,
    ST_LINE_REQ  = 3'd3,
    ST_LINE_WAIT = 3'd4,
    ST_WR_REQ    = 3'd5,
    ST_WR_WAIT   = 3'd6,
    ST_FINISH    = 3'd7
  } ctl_state_e;

  // mmio word offsets
  typedef enum logic [`AFU_MMIO_AW-1:0] {
    REG_DESC    = 'h0,
    REG_SCRATCH = 'h1,
    REG_PARITY  = 'h2
  } mmio_reg_e;

endpackage

//--- hdl/job.sv
`timescale 1ns/100ps

module job (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 job_valid,
  input  capi_pkg::job_cmd_e   job_cmd,
  input  logic                 finish,
  output logic                 running,
  output logic                 done
);

  logic start_cmd;
  logic reset_cmd;

  assign start_cmd = job_valid && (job_cmd == capi_pkg::JOB_START) && !running;
  assign reset_cmd = job_valid && (job_cmd == capi_pkg::JOB_RESET);

  // done is the only way out of running, so one pulse per job
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      running <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (running && (finish || reset_cmd)) begin
        running <= 1'b0;
        done    <= 1'b1;
      end else if (start_cmd) begin
        running <= 1'b1;
      end
    end
  end

  // done marks the falling edge of running
  a_done_ends_job: assert property (
    @(posedge clock) disable iff (!arst_n)
    done |-> !running && $past(running)
  );

endmodule

//--- hdl/mmio.sv
`timescale 1ns/100ps
`include "afu_macros.svh"

module mmio (
  input  logic                    clock,
  input  logic                    arst_n,
  input  logic                    mmio_valid,
  input  logic                    mmio_read,
  input  logic [`AFU_MMIO_AW-1:0] mmio_addr,
  input  logic [`AFU_DATA_W-1:0]  mmio_wdata,
  input  logic [`AFU_DATA_W-1:0]  parity_value,
  output logic                    mmio_ack,
  output logic [`AFU_DATA_W-1:0]  mmio_rdata
);

  logic [`AFU_DATA_W-1:0] scratch;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mmio_ack <= 1'b0;
    end else begin
      mmio_ack <= mmio_valid;
    end
  end

  // only scratch is writable
  always_ff @(posedge clock) begin
    if (mmio_valid && !mmio_read && (mmio_addr == afu_pkg::REG_SCRATCH)) begin
      scratch <= mmio_wdata;
    end
  end

  // read data lines up with the ack, zero for writes and unknown offsets
  always_ff @(posedge clock) begin
    if (mmio_valid) begin
      if (mmio_read) begin
        case (mmio_addr)
          afu_pkg::REG_DESC:    mmio_rdata <= `AFU_DESC_WORD;
          afu_pkg::REG_SCRATCH: mmio_rdata <= scratch;
          afu_pkg::REG_PARITY:  mmio_rdata <= parity_value;
          default:              mmio_rdata <= '0;
        endcase
      end else begin
        mmio_rdata <= '0;
      end
    end
  end

  a_ack_after_valid: assert property (
    @(posedge clock) disable iff (!arst_n)
    mmio_valid |=> mmio_ack
  );

  a_no_spurious_ack: assert property (
    @(posedge clock) disable iff (!arst_n)
    mmio_ack |-> $past(mmio_valid)
  );

endmodule

//--- hdl/control.sv
`timescale 1ns/100ps
`include "afu_macros.svh"

module control (
  input  logic                           clock,
  input  logic                           arst_n,
  input  logic                           running,
  input  logic                           abort,
  input  logic [`AFU_ADDR_W-1:0]         job_wed,
  input  logic [`AFU_TAG_W-1:0]          cmd_room,
  input  logic                           bw_valid,
  input  logic [`AFU_TAG_W-1:0]          bw_tag,
  input  logic [$clog2(`AFU_BEATS)-1:0]  bw_beat,
  input  logic [`AFU_DATA_W-1:0]         bw_data,
  input  logic                           br_valid,
  input  logic [$clog2(`AFU_BEATS)-1:0]  br_beat,
  input  logic                           resp_valid,
  input  logic [`AFU_TAG_W-1:0]          resp_tag,
  input  capi_pkg::resp_code_e           resp_code,
  output logic                           cmd_valid,
  output capi_pkg::mem_cmd_e             cmd_kind,
  output logic [`AFU_TAG_W-1:0]          cmd_tag,
  output logic [`AFU_ADDR_W-1:0]         cmd_addr,
  output logic [`AFU_DATA_W-1:0]         br_data,
  output logic                           finish_pulse,
  output logic [`AFU_DATA_W-1:0]         parity_value
);

  // bytes per cache line, sets the stride between source lines
  localparam int LINE_SHIFT = $clog2(`AFU_BEATS * `AFU_DATA_W / 8);

  afu_pkg::ctl_state_e    state;
  logic [`AFU_ADDR_W-1:0] src_addr;
  logic [`AFU_ADDR_W-1:0] dst_addr;
  logic [`AFU_ADDR_W-1:0] line_cnt;
  logic [`AFU_ADDR_W-1:0] line_idx;
  logic [`AFU_DATA_W-1:0] acc;
  logic                   issue;
  logic                   bw_hit;
  logic                   resp_hit;

  // one command outstanding, so cmd_tag identifies the live transfer
  assign issue    = cmd_room != '0;
  assign bw_hit   = bw_valid && (bw_tag == cmd_tag);
  assign resp_hit = resp_valid && (resp_tag == cmd_tag);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state        <= afu_pkg::ST_IDLE;
      cmd_valid    <= 1'b0;
      finish_pulse <= 1'b0;
      parity_value <= '0;
    end else begin
      cmd_valid    <= 1'b0;
      finish_pulse <= 1'b0;
      if (abort) begin
        state <= afu_pkg::ST_IDLE;
      end else begin
        case (state)
          afu_pkg::ST_IDLE: begin
            if (running) begin
              state <= afu_pkg::ST_WED_REQ;
            end
          end
          afu_pkg::ST_WED_REQ: begin
            if (issue) begin
              cmd_valid <= 1'b1;
              state     <= afu_pkg::ST_WED_WAIT;
            end
          end
          afu_pkg::ST_WED_WAIT: begin
            if (resp_hit && (line_cnt == '0)) begin
              state <= afu_pkg::ST_WR_REQ;
            end else if (resp_hit) begin
              state <= afu_pkg::ST_LINE_REQ;
            end
          end
          afu_pkg::ST_LINE_REQ: begin
            if (issue) begin
              cmd_valid <= 1'b1;
              state     <= afu_pkg::ST_LINE_WAIT;
            end
          end
          afu_pkg::ST_LINE_WAIT: begin
            if (resp_hit && (line_idx + 1'b1 == line_cnt)) begin
              state <= afu_pkg::ST_WR_REQ;
            end else if (resp_hit) begin
              state <= afu_pkg::ST_LINE_REQ;
            end
          end
          afu_pkg::ST_WR_REQ: begin
            if (issue) begin
              cmd_valid <= 1'b1;
              state     <= afu_pkg::ST_WR_WAIT;
            end
          end
          afu_pkg::ST_WR_WAIT: begin
            if (resp_hit) begin
              finish_pulse <= 1'b1;
              if (resp_code == capi_pkg::RESP_DONE) begin
                parity_value <= acc;
              end
              state <= afu_pkg::ST_FINISH;
            end
          end
          // hold until job drops running so a finished job is not restarted
          afu_pkg::ST_FINISH: begin
            if (!running) begin
              state <= afu_pkg::ST_IDLE;
            end
          end
          default: state <= afu_pkg::ST_IDLE;
        endcase
      end
    end
  end

  // descriptor fields, accumulator and command payload
  always_ff @(posedge clock) begin
    case (state)
      afu_pkg::ST_IDLE: begin
        acc      <= '0;
        line_idx <= '0;
      end
      afu_pkg::ST_WED_REQ: begin
        cmd_kind <= capi_pkg::MEM_READ;
        cmd_tag  <= `AFU_WED_TAG;
        cmd_addr <= job_wed;
      end
      afu_pkg::ST_WED_WAIT: begin
        if (bw_hit) begin
          case (bw_beat)
            2'd0:    src_addr <= bw_data;
            2'd1:    dst_addr <= bw_data;
            2'd2:    line_cnt <= bw_data;
            default: ;
          endcase
        end
      end
      afu_pkg::ST_LINE_REQ: begin
        cmd_kind <= capi_pkg::MEM_READ;
        cmd_tag  <= line_idx[`AFU_TAG_W-1:0];
        cmd_addr <= src_addr + (line_idx << LINE_SHIFT);
      end
      afu_pkg::ST_LINE_WAIT: begin
        if (bw_hit) begin
          acc <= acc ^ bw_data;
        end
        if (resp_hit) begin
          line_idx <= line_idx + 1'b1;
        end
      end
      afu_pkg::ST_WR_REQ: begin
        cmd_kind <= capi_pkg::MEM_WRITE;
        cmd_tag  <= `AFU_WR_TAG;
        cmd_addr <= dst_addr;
      end
      default: ;
    endcase
  end

  // result line, parity in beat 0
  always_ff @(posedge clock) begin
    if (br_valid) begin
      br_data <= (br_beat == '0) ? acc : '0;
    end
  end

  a_room_before_cmd: assert property (
    @(posedge clock) disable iff (!arst_n)
    cmd_valid |-> $past(cmd_room) != '0
  );

  a_cmd_in_job: assert property (
    @(posedge clock) disable iff (!arst_n)
    cmd_valid |-> $past(running)
  );

endmodule

//--- hdl/parity_afu.sv
`timescale 1ns/100ps
`include "afu_macros.svh"

module parity_afu (
  input  logic                           clock,
  input  logic                           arst_n,
  input  logic                           job_valid,
  input  capi_pkg::job_cmd_e             job_cmd,
  input  logic [`AFU_ADDR_W-1:0]         job_wed,
  output logic                           job_running,
  output logic                           job_done,
  output logic                           cmd_valid,
  output capi_pkg::mem_cmd_e             cmd_kind,
  output logic [`AFU_TAG_W-1:0]          cmd_tag,
  output logic [`AFU_ADDR_W-1:0]         cmd_addr,
  input  logic [`AFU_TAG_W-1:0]          cmd_room,
  input  logic                           bw_valid,
  input  logic [`AFU_TAG_W-1:0]          bw_tag,
  input  logic [$clog2(`AFU_BEATS)-1:0]  bw_beat,
  input  logic [`AFU_DATA_W-1:0]         bw_data,
  input  logic                           br_valid,
  input  logic [`AFU_TAG_W-1:0]          br_tag,
  input  logic [$clog2(`AFU_BEATS)-1:0]  br_beat,
  output logic [`AFU_DATA_W-1:0]         br_data,
  input  logic                           resp_valid,
  input  logic [`AFU_TAG_W-1:0]          resp_tag,
  input  capi_pkg::resp_code_e           resp_code,
  input  logic                           mmio_valid,
  input  logic                           mmio_read,
  input  logic [`AFU_MMIO_AW-1:0]        mmio_addr,
  input  logic [`AFU_DATA_W-1:0]         mmio_wdata,
  output logic                           mmio_ack,
  output logic [`AFU_DATA_W-1:0]         mmio_rdata,
  output logic                           timebase_request,
  output logic                           parity_enabled
);

  // registered host inputs
  logic                           job_valid_r;
  capi_pkg::job_cmd_e             job_cmd_r;
  logic [`AFU_ADDR_W-1:0]         job_wed_r;
  logic [`AFU_TAG_W-1:0]          cmd_room_r;
  logic                           bw_valid_r;
  logic [`AFU_TAG_W-1:0]          bw_tag_r;
  logic [$clog2(`AFU_BEATS)-1:0]  bw_beat_r;
  logic [`AFU_DATA_W-1:0]         bw_data_r;
  logic                           br_valid_r;
  logic [`AFU_TAG_W-1:0]          br_tag_r;
  logic [$clog2(`AFU_BEATS)-1:0]  br_beat_r;
  logic                           resp_valid_r;
  logic [`AFU_TAG_W-1:0]          resp_tag_r;
  capi_pkg::resp_code_e           resp_code_r;
  logic                           mmio_valid_r;
  logic                           mmio_read_r;
  logic [`AFU_MMIO_AW-1:0]        mmio_addr_r;
  logic [`AFU_DATA_W-1:0]         mmio_wdata_r;

  // core outputs before the output stage
  logic                           running_c;
  logic                           done_c;
  logic                           cmd_valid_c;
  capi_pkg::mem_cmd_e             cmd_kind_c;
  logic [`AFU_TAG_W-1:0]          cmd_tag_c;
  logic [`AFU_ADDR_W-1:0]         cmd_addr_c;
  logic [`AFU_DATA_W-1:0]         br_data_c;
  logic                           mmio_ack_c;
  logic [`AFU_DATA_W-1:0]         mmio_rdata_c;
  logic                           finish_pulse;
  logic [`AFU_DATA_W-1:0]         parity_value;

  assign timebase_request = 1'b0;
  assign parity_enabled   = 1'b0;

  // strobes, room count and output valids
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      job_valid_r  <= 1'b0;
      cmd_room_r   <= '0;
      bw_valid_r   <= 1'b0;
      br_valid_r   <= 1'b0;
      resp_valid_r <= 1'b0;
      mmio_valid_r <= 1'b0;
      job_running  <= 1'b0;
      job_done     <= 1'b0;
      cmd_valid    <= 1'b0;
      mmio_ack     <= 1'b0;
    end else begin
      job_valid_r  <= job_valid;
      cmd_room_r   <= cmd_room;
      bw_valid_r   <= bw_valid;
      br_valid_r   <= br_valid;
      resp_valid_r <= resp_valid;
      mmio_valid_r <= mmio_valid;
      job_running  <= running_c;
      job_done     <= done_c;
      cmd_valid    <= cmd_valid_c;
      mmio_ack     <= mmio_ack_c;
    end
  end

  // payload on both sides
  always_ff @(posedge clock) begin
    job_cmd_r    <= job_cmd;
    if (job_valid) begin
      job_wed_r <= job_wed;
    end
    bw_tag_r     <= bw_tag;
    bw_beat_r    <= bw_beat;
    bw_data_r    <= bw_data;
    br_tag_r     <= br_tag;
    br_beat_r    <= br_beat;
    resp_tag_r   <= resp_tag;
    resp_code_r  <= resp_code;
    mmio_read_r  <= mmio_read;
    mmio_addr_r  <= mmio_addr;
    mmio_wdata_r <= mmio_wdata;
    cmd_kind     <= cmd_kind_c;
    cmd_tag      <= cmd_tag_c;
    cmd_addr     <= cmd_addr_c;
    br_data      <= br_data_c;
    mmio_rdata   <= mmio_rdata_c;
  end

  job job0 (
    .clock    (clock),
    .arst_n   (arst_n),
    .job_valid(job_valid_r),
    .job_cmd  (job_cmd_r),
    .finish   (finish_pulse),
    .running  (running_c),
    .done     (done_c)
  );

  mmio mmio0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .mmio_valid  (mmio_valid_r),
    .mmio_read   (mmio_read_r),
    .mmio_addr   (mmio_addr_r),
    .mmio_wdata  (mmio_wdata_r),
    .parity_value(parity_value),
    .mmio_ack    (mmio_ack_c),
    .mmio_rdata  (mmio_rdata_c)
  );

  // buffer reads only serve the result write
  control control0 (
    .clock       (clock),
    .arst_n      (arst_n),
    .running     (running_c),
    .abort       (done_c),
    .job_wed     (job_wed_r),
    .cmd_room    (cmd_room_r),
    .bw_valid    (bw_valid_r),
    .bw_tag      (bw_tag_r),
    .bw_beat     (bw_beat_r),
    .bw_data     (bw_data_r),
    .br_valid    (br_valid_r && (br_tag_r == `AFU_WR_TAG)),
    .br_beat     (br_beat_r),
    .resp_valid  (resp_valid_r),
    .resp_tag    (resp_tag_r),
    .resp_code   (resp_code_r),
    .cmd_valid   (cmd_valid_c),
    .cmd_kind    (cmd_kind_c),
    .cmd_tag     (cmd_tag_c),
    .cmd_addr    (cmd_addr_c),
    .br_data     (br_data_c),
    .finish_pulse(finish_pulse),
    .parity_value(parity_value)
  );

endmodule

//--- dv/afu_checker.sv
`timescale 1ns/100ps
`include "afu_macros.svh"

module afu_checker (
  input logic                          clock,
  input logic                          arst_n,
  input logic [`AFU_TAG_W-1:0]         cmd_room,
  input logic                          cmd_valid,
  input logic                          br_valid,
  input logic [$clog2(`AFU_BEATS)-1:0] br_beat,
  input logic [`AFU_DATA_W-1:0]        br_data,
  input logic                          mmio_valid,
  input logic                          mmio_ack,
  input logic                          job_running,
  input logic                          job_done,
  input logic [`AFU_DATA_W-1:0]        exp_parity
);

  int errors = 0;
  int mark = 0;
  int tests = 0;
  int done_count = 0;
  int cmd_count = 0;

  // port history, oldest entry is three edges back
  logic [2:0] room_zero_h;
  logic [2:0] br_v_h;
  logic [5:0] br_b_h;
  logic [2:0] mmio_v_h;

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == mark) begin
      $display("test %0d %s: passed", tests, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, name, errors - mark);
    end
    mark = errors;
  endtask

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      room_zero_h <= '0;
      br_v_h      <= '0;
      br_b_h      <= '0;
      mmio_v_h    <= '0;
    end else begin
      room_zero_h <= {room_zero_h[1:0], cmd_room == '0};
      br_v_h      <= {br_v_h[1:0], br_valid};
      br_b_h      <= {br_b_h[3:0], br_beat};
      mmio_v_h    <= {mmio_v_h[1:0], mmio_valid};
      if (cmd_valid) begin
        cmd_count++;
        if (room_zero_h[2]) begin
          note_failure("cmd_valid issued while cmd_room was zero");
        end
      end
      // ack three edges after the request at the ports
      check_value("mmio_ack", {63'd0, mmio_v_h[2]}, {63'd0, mmio_ack});
      if (br_v_h[2]) begin
        check_value("br_data", (br_b_h[5:4] == 2'd0) ? exp_parity : 64'd0, br_data);
      end
      if (job_done) begin
        done_count++;
        if (job_running) begin
          note_failure("job_running still high while job_done pulsed");
        end
      end
    end
  end

endmodule

//--- dv/tb_parity_afu.sv
`timescale 1ns/100ps
`include "afu_macros.svh"

module tb_parity_afu;

  // lines over all jobs are 1 + 3 + 8 + 5 stalled + 8 aborted
  localparam int TOTAL_LINES = 25;
  localparam int WATCH_CYCLES = TOTAL_LINES * 40 + 2000;

  logic                    clock;
  logic                    arst_n;
  logic                    job_valid;
  capi_pkg::job_cmd_e      job_cmd;
  logic [63:0]             job_wed;
  logic                    job_running;
  logic                    job_done;
  logic                    cmd_valid;
  capi_pkg::mem_cmd_e      cmd_kind;
  logic [7:0]              cmd_tag;
  logic [63:0]             cmd_addr;
  logic [7:0]              cmd_room;
  logic                    bw_valid;
  logic [7:0]              bw_tag;
  logic [1:0]              bw_beat;
  logic [63:0]             bw_data;
  logic                    br_valid;
  logic [7:0]              br_tag;
  logic [1:0]              br_beat;
  logic [63:0]             br_data;
  logic                    resp_valid;
  logic [7:0]              resp_tag;
  capi_pkg::resp_code_e    resp_code;
  logic                    mmio_valid;
  logic                    mmio_read;
  logic [23:0]             mmio_addr;
  logic [63:0]             mmio_wdata;
  logic                    mmio_ack;
  logic [63:0]             mmio_rdata;
  logic                    timebase_request;
  logic                    parity_enabled;

  // host memory of words keyed by byte address
  logic [63:0] mem [logic [63:0]];
  logic [73:0] cmd_q [$];
  logic [31:0] rng_state;
  logic [31:0] stall_rng;
  logic [63:0] exp_parity;
  logic [63:0] wr_parity;
  logic [63:0] wr_addr;
  int          wr_count;
  logic        stall_en;
  int          stall_cnt;

  parity_afu dut0 (.*);

  afu_checker chk0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .cmd_room   (cmd_room),
    .cmd_valid  (cmd_valid),
    .br_valid   (br_valid),
    .br_beat    (br_beat),
    .br_data    (br_data),
    .mmio_valid (mmio_valid),
    .mmio_ack   (mmio_ack),
    .job_running(job_running),
    .job_done   (job_done),
    .exp_parity (exp_parity)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [63:0] read_mem(input logic [63:0] addr);
    return mem.exists(addr) ? mem[addr] : 64'd0;
  endfunction

  // expected parity is the xor of every word in the source lines
  function automatic logic [63:0] ref_parity(input logic [63:0] src, input int lines);
    logic [63:0] acc;
    acc = '0;
    for (int i = 0; i < lines * 4; i++) begin
      acc = acc ^ read_mem(src + 64'(8 * i));
    end
    return acc;
  endfunction

  task automatic setup_job(input int lines, input logic [63:0] wed, input logic [63:0] src,
                           input logic [63:0] dst);
    mem[wed]      = src;
    mem[wed + 8]  = dst;
    mem[wed + 16] = 64'(lines);
    mem[wed + 24] = 64'd0;
    for (int i = 0; i < lines * 4; i++) begin
      rng_state = xorshift32(rng_state);
      mem[src + 64'(8 * i)][63:32] = rng_state;
      rng_state = xorshift32(rng_state);
      mem[src + 64'(8 * i)][31:0] = rng_state;
    end
    exp_parity = ref_parity(src, lines);
  endtask

  task automatic send_job_cmd(input capi_pkg::job_cmd_e cmd, input logic [63:0] wed);
    @(posedge clock);
    job_valid <= 1'b1;
    job_cmd   <= cmd;
    job_wed   <= wed;
    @(posedge clock);
    job_valid <= 1'b0;
    job_cmd   <= capi_pkg::JOB_NONE;
  endtask

  task automatic wait_done(input int max_cycles);
    int n;
    n = 0;
    while (!job_done && n < max_cycles) begin
      @(posedge clock);
      n++;
    end
    if (!job_done) begin
      chk0.note_failure("job_done never arrived");
    end
  endtask

  task automatic run_job(input int lines, input logic [63:0] wed, input logic [63:0] src,
                         input logic [63:0] dst);
    int done0;
    int wr0;
    setup_job(lines, wed, src, dst);
    done0 = chk0.done_count;
    wr0   = wr_count;
    send_job_cmd(capi_pkg::JOB_START, wed);
    wait_done(lines * 200 + 400);
    repeat (4) @(posedge clock);
    chk0.check_value("job_done pulses", 64'd1, 64'(chk0.done_count - done0));
    chk0.check_value("result writes", 64'd1, 64'(wr_count - wr0));
    chk0.check_value("write cmd_addr", dst, wr_addr);
    chk0.check_value("written parity", exp_parity, wr_parity);
  endtask

  task automatic mmio_access(input logic rd, input logic [23:0] addr, input logic [63:0] wdata,
                             output logic [63:0] rdata);
    int n;
    @(posedge clock);
    mmio_valid <= 1'b1;
    mmio_read  <= rd;
    mmio_addr  <= addr;
    mmio_wdata <= wdata;
    @(posedge clock);
    mmio_valid <= 1'b0;
    n = 0;
    while (!mmio_ack && n < 20) begin
      @(posedge clock);
      n++;
    end
    if (!mmio_ack) begin
      chk0.note_failure("mmio access got no ack");
    end
    rdata = mmio_rdata;
  endtask

  always @(posedge clock) begin
    if (arst_n && cmd_valid) begin
      cmd_q.push_back({cmd_kind, cmd_tag, cmd_addr});
    end
  end

  // room drops to zero for random stretches while stalling
  always @(posedge clock) begin
    if (!stall_en) begin
      cmd_room  <= 8'd4;
      stall_cnt = 0;
    end else if (stall_cnt > 0) begin
      stall_cnt--;
    end else begin
      stall_rng = xorshift32(stall_rng);
      if (cmd_room != 8'd0) begin
        cmd_room  <= 8'd0;
        stall_cnt = 4 + int'(stall_rng % 16);
      end else begin
        cmd_room  <= 8'd4;
        stall_cnt = int'(stall_rng % 3);
      end
    end
  end

  // host memory model serving one command at a time
  initial begin : host_model
    logic [73:0] c;
    logic [63:0] a;
    logic [7:0]  t;
    forever begin
      @(posedge clock);
      if (cmd_q.size() != 0) begin
        c = cmd_q.pop_front();
        a = c[63:0];
        t = c[71:64];
        if (c[73:72] == capi_pkg::MEM_READ) begin
          for (int b = 0; b < 4; b++) begin
            bw_valid <= 1'b1;
            bw_tag   <= t;
            bw_beat  <= 2'(b);
            bw_data  <= read_mem(a + 64'(8 * b));
            @(posedge clock);
          end
          bw_valid <= 1'b0;
        end else begin
          chk0.check_value("cmd_kind", 64'(capi_pkg::MEM_WRITE), 64'(c[73:72]));
          for (int b = 0; b < 4; b++) begin
            br_valid <= 1'b1;
            br_tag   <= t;
            br_beat  <= 2'(b);
            @(posedge clock);
          end
          br_valid <= 1'b0;
          // beat 0 data is on the port by now
          wr_parity = br_data;
          wr_addr   = a;
          repeat (3) @(posedge clock);
        end
        resp_valid <= 1'b1;
        resp_tag   <= t;
        resp_code  <= capi_pkg::RESP_DONE;
        @(posedge clock);
        resp_valid <= 1'b0;
        if (c[73:72] == capi_pkg::MEM_WRITE) begin
          wr_count++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCH_CYCLES) @(posedge clock);
    $display("watchdog: run did not end within %0d cycles", WATCH_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [63:0] rd;
    int          c0;
    int          c1;
    int          done0;
    int          n;
    arst_n     = 1'b0;
    job_valid  = 1'b0;
    job_cmd    = capi_pkg::JOB_NONE;
    job_wed    = '0;
    cmd_room   = 8'd4;
    bw_valid   = 1'b0;
    bw_tag     = '0;
    bw_beat    = '0;
    bw_data    = '0;
    br_valid   = 1'b0;
    br_tag     = '0;
    br_beat    = '0;
    resp_valid = 1'b0;
    resp_tag   = '0;
    resp_code  = capi_pkg::RESP_DONE;
    mmio_valid = 1'b0;
    mmio_read  = 1'b0;
    mmio_addr  = '0;
    mmio_wdata = '0;
    rng_state  = 32'he743;
    stall_rng  = xorshift32(32'he743 ^ 32'h5555);
    stall_en   = 1'b0;
    wr_count   = 0;
    wr_parity  = '0;
    wr_addr    = '0;
    exp_parity = '0;
    repeat (8) @(posedge clock);
    arst_n <= 1'b1;
    repeat (3) @(posedge clock);

    chk0.check_value("cmd_valid", 64'd0, {63'd0, cmd_valid});
    chk0.check_value("job_running", 64'd0, {63'd0, job_running});
    chk0.check_value("job_done", 64'd0, {63'd0, job_done});
    chk0.check_value("mmio_ack", 64'd0, {63'd0, mmio_ack});
    chk0.check_value("timebase_request", 64'd0, {63'd0, timebase_request});
    chk0.check_value("parity_enabled", 64'd0, {63'd0, parity_enabled});
    chk0.report_test("reset state");

    mmio_access(1'b0, afu_pkg::REG_SCRATCH, 64'h5a5a_1234_c3c3_0f0f, rd);
    mmio_access(1'b1, afu_pkg::REG_SCRATCH, 64'd0, rd);
    chk0.check_value("mmio_rdata scratch", 64'h5a5a_1234_c3c3_0f0f, rd);
    mmio_access(1'b1, afu_pkg::REG_DESC, 64'd0, rd);
    chk0.check_value("mmio_rdata desc", `AFU_DESC_WORD, rd);
    chk0.report_test("mmio scratch and descriptor");

    run_job(1, 64'h1000, 64'h10000, 64'h2000);
    chk0.report_test("job of 1 line");
    run_job(3, 64'h1100, 64'h20000, 64'h2100);
    chk0.report_test("job of 3 lines");
    run_job(8, 64'h1200, 64'h30000, 64'h2200);
    chk0.report_test("job of 8 lines");

    stall_en = 1'b1;
    run_job(5, 64'h1300, 64'h40000, 64'h2300);
    stall_en = 1'b0;
    chk0.report_test("job under cmd_room stalls");

    mmio_access(1'b1, afu_pkg::REG_PARITY, 64'd0, rd);
    chk0.check_value("mmio_rdata parity", exp_parity, rd);
    chk0.report_test("parity register after job");

    // reset command once the line reads are under way
    setup_job(8, 64'h1400, 64'h50000, 64'h2400);
    done0 = chk0.done_count;
    c0    = chk0.cmd_count;
    send_job_cmd(capi_pkg::JOB_START, 64'h1400);
    n = 0;
    while (chk0.cmd_count < c0 + 3 && n < 500) begin
      @(posedge clock);
      n++;
    end
    send_job_cmd(capi_pkg::JOB_RESET, 64'h1400);
    wait_done(100);
    chk0.check_value("job_running", 64'd0, {63'd0, job_running});
    repeat (4) @(posedge clock);
    c1 = chk0.cmd_count;
    repeat (60) @(posedge clock);
    chk0.check_value("commands after reset", 64'(c1), 64'(chk0.cmd_count));
    chk0.check_value("job_done pulses", 64'd1, 64'(chk0.done_count - done0));
    chk0.report_test("reset command mid job");

    $display("tests: %0d, errors: %0d", chk0.tests, chk0.errors);
    if (chk0.errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+hdl
hdl/capi_pkg.sv
hdl/afu_pkg.sv
hdl/job.sv
hdl/mmio.sv
hdl/control.sv
hdl/parity_afu.sv
dv/afu_checker.sv
dv/tb_parity_afu.sv

//--- Makefile
TOP := tb_parity_afu
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
